//--- rowsum.f
source/rowsum_pkg.sv
source/rowsum_ctrl.sv
source/scan_counter.sv
source/frame_buffer.sv
source/window_lane.sv
source/result_collector.sv
source/rowsum_top.sv
test/rowsum_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= rowsum_tb
FILELIST  ?= rowsum.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/rowsum_tb.sv
`timescale 1ns/10ps

module rowsum_tb;

  logic                    clk;
  logic                    rst_n;
  logic                    start;
  logic                    wr_en;
  rowsum_pkg::addr_t       wr_addr;
  rowsum_pkg::sample_vec_t wr_data;
  logic                    res_valid;
  rowsum_pkg::result_t     res;
  logic                    frame_done;
  logic                    busy;

  // host copy of the frame, indexed row, column, lane.
  logic [rowsum_pkg::SAMPLE_W-1:0] frame [rowsum_pkg::ROWS][rowsum_pkg::COLS][rowsum_pkg::LANES];

  int errors;
  int tests;
  int failed;
  int seed;
  int timeout_cycles;
  int per_row;

  rowsum_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .res_valid  (res_valid),
    .res        (res),
    .frame_done (frame_done),
    .busy       (busy)
  );

  always #2 clk = ~clk;

  task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("error: %s", what);
      errors++;
    end
  endtask

  task automatic report(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // sum of the WIN samples ending at column c.
  function automatic logic [rowsum_pkg::SUM_W-1:0] window_sum(input int r, input int c,
                                                              input int l);
    int acc;
    acc = 0;
    for (int k = c - rowsum_pkg::WIN + 1; k <= c; k++) begin
      acc += int'(frame[2'(r)][4'(k)][2'(l)]);
    end
    return rowsum_pkg::SUM_W'(acc);
  endfunction

  // kind 0 is a ramp, 1 is random, 2 is all ones.
  task automatic fill_frame(input int kind);
    for (int r = 0; r < rowsum_pkg::ROWS; r++) begin
      for (int c = 0; c < rowsum_pkg::COLS; c++) begin
        for (int l = 0; l < rowsum_pkg::LANES; l++) begin
          case (kind)
            0: frame[2'(r)][4'(c)][2'(l)] = 8'(r + c + l);
            1: frame[2'(r)][4'(c)][2'(l)] = 8'($random(seed));
            default: frame[2'(r)][4'(c)][2'(l)] = 8'hff;
          endcase
        end
      end
    end
  endtask

  task automatic load_frame();
    for (int r = 0; r < rowsum_pkg::ROWS; r++) begin
      for (int c = 0; c < rowsum_pkg::COLS; c++) begin
        @(posedge clk);
        #1;
        wr_en   = 1'b1;
        wr_addr = rowsum_pkg::addr_t'(r * rowsum_pkg::COLS + c);
        for (int l = 0; l < rowsum_pkg::LANES; l++) begin
          wr_data.lane[2'(l)] = frame[2'(r)][4'(c)][2'(l)];
        end
      end
    end
    @(posedge clk);
    #1;
    wr_en = 1'b0;
  endtask

  // results arrive row by row, columns WIN-1 to COLS-1.
  task automatic check_result(input int n);
    int r;
    int c;
    r = n / per_row;
    c = rowsum_pkg::WIN - 1 + n % per_row;
    check_val("res.row", 32'(res.row), 32'(r));
    check_val("res.col", 32'(res.col), 32'(c));
    for (int l = 0; l < rowsum_pkg::LANES; l++) begin
      check_val($sformatf("res.sums.lane[%0d]", l), 32'(res.sums.lane[2'(l)]),
                32'(window_sum(r, c, l)));
    end
  endtask

  task automatic run_frame(input logic poke);
    int n;
    int t;
    n = 0;
    t = 0;
    @(posedge clk);
    #1;
    start = 1'b1;
    while (n < rowsum_pkg::ROWS * per_row && t < timeout_cycles) begin
      @(posedge clk);
      #1;
      // second starts in the middle and near the end of the frame.
      start = poke && (n == 2 || n == rowsum_pkg::ROWS * per_row - 2);
      t++;
      check_true(busy, "busy low before the last result");
      check_true(!frame_done, "frame_done before the last result");
      if (res_valid) begin
        check_result(n);
        n++;
      end
    end
    start = 1'b0;
    check_true(n == rowsum_pkg::ROWS * per_row, "timeout waiting for results");
    t = 0;
    while (!frame_done && t < timeout_cycles) begin
      @(posedge clk);
      #1;
      t++;
      check_true(!res_valid, "extra result after the last one");
    end
    check_true(frame_done, "timeout waiting for frame_done");
    check_true(t == 1, "frame_done not one cycle after the last result");
    check_true(!busy, "busy still high at frame_done");
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      #1;
      check_true(!res_valid && !frame_done && !busy, "activity after the frame ended");
    end
  endtask

  task automatic test_idle();
    int e0;
    e0 = errors;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1;
      check_true(!res_valid && !frame_done && !busy, "output active while idle");
    end
    report("test 1 idle after reset", e0);
  endtask

  task automatic test_frame(input string name, input int kind);
    int e0;
    e0 = errors;
    fill_frame(kind);
    load_frame();
    run_frame(1'b0);
    report(name, e0);
  endtask

  task automatic test_busy_start();
    int e0;
    e0 = errors;
    fill_frame(1);
    load_frame();
    run_frame(1'b1);
    fill_frame(0);
    load_frame();
    run_frame(1'b0);
    report("test 5 start while busy and restart", e0);
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    start          = 1'b0;
    wr_en          = 1'b0;
    wr_addr        = '0;
    wr_data        = '0;
    errors         = 0;
    tests          = 0;
    failed         = 0;
    seed           = 32'h2b77_67ae;
    timeout_cycles = 500;
    per_row        = rowsum_pkg::COLS - rowsum_pkg::WIN + 1;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_idle();
    test_frame("test 2 ramp frame", 0);
    test_frame("test 3 random frame", 1);
    test_frame("test 4 full scale frame", 2);
    test_busy_start();
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- source/rowsum_top.sv
`timescale 1ns/10ps

module rowsum_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic                     wr_en,
  input  rowsum_pkg::addr_t        wr_addr,
  input  rowsum_pkg::sample_vec_t  wr_data,
  output logic                     res_valid,
  output rowsum_pkg::result_t      res,
  output logic                     frame_done,
  output logic                     busy
);

  rowsum_pkg::ctrl_t       ctl;
  logic                    start_gt_2;
  logic                    row_eq_max;
  rowsum_pkg::col_t        col;
  rowsum_pkg::row_t        row;
  rowsum_pkg::sample_vec_t samples;
  rowsum_pkg::col_t        sample_col;
  rowsum_pkg::row_t        sample_row;
  wire rowsum_pkg::sum_vec_t sums;

  rowsum_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .start_gt_2 (start_gt_2),
    .col        (col),
    .row_eq_max (row_eq_max),
    .ctl        (ctl),
    .busy       (busy)
  );

  scan_counter u_scan (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctl        (ctl),
    .start_gt_2 (start_gt_2),
    .col        (col),
    .row        (row),
    .row_eq_max (row_eq_max)
  );

  frame_buffer u_fbuf (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .busy       (busy),
    .col        (col),
    .row        (row),
    .ctl        (ctl),
    .samples    (samples),
    .sample_col (sample_col),
    .sample_row (sample_row)
  );

  // one lane per channel.
  for (genvar i = 0; i < rowsum_pkg::LANES; i++) begin : g_lane
    window_lane u_lane (
      .clk    (clk),
      .rst_n  (rst_n),
      .clear  (ctl.ld_en),
      .shift  (ctl.sum_en),
      .sample (samples.lane[i]),
      .sum    (sums.lane[i])
    );
  end

  result_collector u_coll (
    .clk        (clk),
    .rst_n      (rst_n),
    .emit       (ctl.sum_en),
    .sums       (sums),
    .res_col    (sample_col),
    .res_row    (sample_row),
    .last       (ctl.progress_done),
    .res_valid  (res_valid),
    .res        (res),
    .frame_done (frame_done)
  );

endmodule

//--- source/result_collector.sv
`timescale 1ns/10ps

module result_collector (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  emit,
  input  rowsum_pkg::sum_vec_t  sums,
  input  rowsum_pkg::col_t      res_col,
  input  rowsum_pkg::row_t      res_row,
  input  logic                  last,
  output logic                  res_valid,
  output rowsum_pkg::result_t   res,
  output logic                  frame_done
);

  logic             v1;
  logic             v2;
  logic             last_q;
  logic             res_last;
  logic             hit;
  rowsum_pkg::col_t c2;
  rowsum_pkg::row_t r2;

  // v1 sits with the sample, v2 with the lane sums.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v1     <= 1'b0;
      v2     <= 1'b0;
      last_q <= 1'b0;
    end else begin
      v1     <= emit;
      v2     <= v1;
      last_q <= last;
    end
  end

  always_ff @(posedge clk) begin
    c2 <= res_col;
    r2 <= res_row;
  end

  // full window once the column reaches win-1.
  assign hit = v2 && (c2 >= rowsum_pkg::col_t'(rowsum_pkg::WIN - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid  <= 1'b0;
      res_last   <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      res_valid  <= hit;
      res_last   <= hit && last_q;
      frame_done <= res_last;
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      res.row  <= r2;
      res.col  <= c2;
      res.sums <= sums;
    end
  end

endmodule

//--- source/window_lane.sv
`timescale 1ns/10ps

module window_lane (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             clear,
  input  logic                             shift,
  input  logic [rowsum_pkg::SAMPLE_W-1:0]  sample,
  output logic [rowsum_pkg::SUM_W-1:0]     sum
);

  localparam int PAD = rowsum_pkg::SUM_W - rowsum_pkg::SAMPLE_W;

  logic [rowsum_pkg::WIN-1:0][rowsum_pkg::SAMPLE_W-1:0] win;
  logic                                                 shift_q;
  logic                                                 clear_q;
  logic [rowsum_pkg::SUM_W-1:0]                         add_ext;
  logic [rowsum_pkg::SUM_W-1:0]                         sub_ext;

  // controls line up with the registered sample from the frame buffer.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_q <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      shift_q <= shift;
      clear_q <= clear;
    end
  end

  assign add_ext = {{PAD{1'b0}}, sample};
  assign sub_ext = {{PAD{1'b0}}, win[rowsum_pkg::WIN-1]};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum <= '0;
    end else if (clear_q) begin
      sum <= '0;
    end else if (shift_q) begin
      // oldest sample drops out as the new one enters.
      sum <= sum + add_ext - sub_ext;
    end
  end

  always_ff @(posedge clk) begin
    if (clear_q) begin
      win <= '0;
    end else if (shift_q) begin
      win <= {win[rowsum_pkg::WIN-2:0], sample};
    end
  end

  a_sum_bound : assert property (@(posedge clk) disable iff (!rst_n)
    sum <= rowsum_pkg::SUM_W'(rowsum_pkg::WIN * ((1 << rowsum_pkg::SAMPLE_W) - 1)));

endmodule

//--- source/frame_buffer.sv
`timescale 1ns/10ps

module frame_buffer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wr_en,
  input  rowsum_pkg::addr_t        wr_addr,
  input  rowsum_pkg::sample_vec_t  wr_data,
  input  logic                     busy,
  input  rowsum_pkg::col_t         col,
  input  rowsum_pkg::row_t         row,
  input  rowsum_pkg::ctrl_t        ctl,
  output rowsum_pkg::sample_vec_t  samples,
  output rowsum_pkg::col_t         sample_col,
  output rowsum_pkg::row_t         sample_row
);

  localparam int DEPTH = rowsum_pkg::ROWS * rowsum_pkg::COLS;

  rowsum_pkg::sample_vec_t mem [DEPTH];
  rowsum_pkg::addr_t       rd_addr;

  // row-major layout.
  assign rd_addr = rowsum_pkg::addr_t'(row) * rowsum_pkg::addr_t'(rowsum_pkg::COLS) +
                   rowsum_pkg::addr_t'(col);

  // host writes only land while the scan is stopped.
  always_ff @(posedge clk) begin
    if (wr_en && !busy && (wr_addr < rowsum_pkg::addr_t'(DEPTH))) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // one column per counting cycle, tagged with where it came from.
  always_ff @(posedge clk) begin
    if (ctl.sum_en) begin
      samples    <= mem[rd_addr];
      sample_col <= col;
      sample_row <= row;
    end
  end

  a_no_write_busy : assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> !busy);

endmodule

//--- source/scan_counter.sv
`timescale 1ns/10ps

module scan_counter (
  input  logic               clk,
  input  logic               rst_n,
  input  rowsum_pkg::ctrl_t  ctl,
  output logic               start_gt_2,
  output rowsum_pkg::col_t   col,
  output rowsum_pkg::row_t   row,
  output logic               row_eq_max
);

  logic [1:0] warm;

  assign start_gt_2 = (warm > 2'(rowsum_pkg::WARMUP));

  // true on the final column of the final row only.
  assign row_eq_max = (row == 2'(rowsum_pkg::ROWS - 1)) &&
                      (col == 4'(rowsum_pkg::COLS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n || ctl.reset_en) begin
      warm <= '0;
    end else if (ctl.start_en && !start_gt_2) begin
      warm <= warm + 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || ctl.reset_en) begin
      col <= '0;
    end else if (ctl.ld_en) begin
      col <= '0;
    end else if (ctl.count_en) begin
      // wraps after the last column.
      if (col == 4'(rowsum_pkg::COLS - 1)) begin
        col <= '0;
      end else begin
        col <= col + 4'd1;
      end
    end
  end

  // row boundary pulse from the controller moves to the next row.
  always_ff @(posedge clk) begin
    if (!rst_n || ctl.reset_en) begin
      row <= '0;
    end else if (ctl.ld_en && ctl.done_o) begin
      row <= row + 2'd1;
    end
  end

  a_col_range : assert property (@(posedge clk) disable iff (!rst_n)
    col < 4'(rowsum_pkg::COLS));

endmodule

//--- source/rowsum_ctrl.sv
`timescale 1ns/10ps

module rowsum_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic                start_gt_2,
  input  rowsum_pkg::col_t    col,
  input  logic                row_eq_max,
  output rowsum_pkg::ctrl_t   ctl,
  output logic                busy
);

  rowsum_pkg::ctrl_state_t state;
  rowsum_pkg::ctrl_state_t next_state;
  rowsum_pkg::ctrl_state_t prev_state;

  logic [rowsum_pkg::DRAIN-1:0] drain;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= rowsum_pkg::st_idle;
      prev_state <= rowsum_pkg::st_idle;
      drain      <= '0;
    end else begin
      state      <= next_state;
      prev_state <= state;
      drain      <= {drain[rowsum_pkg::DRAIN-2:0], ctl.progress_done};
    end
  end

  // stays high until the last result of the frame has left the collector.
  assign busy = (state != rowsum_pkg::st_idle) || (|drain);

  always_comb begin
    next_state = state;
    case (state)
      rowsum_pkg::st_idle:
        next_state = (start && !busy) ? rowsum_pkg::st_start : rowsum_pkg::st_idle;
      rowsum_pkg::st_start:
        next_state = start_gt_2 ? rowsum_pkg::st_start_row : rowsum_pkg::st_start;
      rowsum_pkg::st_start_row:
        next_state = rowsum_pkg::st_sum_en;
      rowsum_pkg::st_sum_en:
        next_state = (col > 4'd7) ? rowsum_pkg::st_cum_en : rowsum_pkg::st_sum_en;
      rowsum_pkg::st_cum_en: begin
        if (row_eq_max) begin
          next_state = rowsum_pkg::st_finish_all;
        end else if (col > 4'(rowsum_pkg::COLS - 2)) begin
          next_state = rowsum_pkg::st_start_row;
        end else begin
          next_state = rowsum_pkg::st_cum_en;
        end
      end
      rowsum_pkg::st_finish_all:
        next_state = rowsum_pkg::st_idle;
      default:
        next_state = rowsum_pkg::st_idle;
    endcase
  end

  always_comb begin
    ctl = '0;
    case (state)
      rowsum_pkg::st_start: begin
        ctl.start_en = 1'b1;
      end
      rowsum_pkg::st_start_row: begin
        ctl.count_en = 1'b1;
        ctl.ld_en    = 1'b1;
        // row boundary.
        if (prev_state == rowsum_pkg::st_cum_en) begin
          ctl.done_o = 1'b1;
        end
      end
      rowsum_pkg::st_sum_en: begin
        ctl.count_en = 1'b1;
        ctl.sum_en   = 1'b1;
      end
      rowsum_pkg::st_cum_en: begin
        ctl.count_en = 1'b1;
        ctl.sum_en   = 1'b1;
        ctl.cum_en   = 1'b1;
      end
      rowsum_pkg::st_finish_all: begin
        ctl.progress_done = 1'b1;
        ctl.reset_en      = 1'b1;
      end
      default: begin
        ctl = '0;
      end
    endcase
  end

  // finish comes out of the last column's cum cycle and never overlaps it.
  a_finish_after_cum : assert property (@(posedge clk) disable iff (!rst_n)
    ctl.progress_done |-> !ctl.cum_en &&
                          $past(ctl.cum_en && (col == 4'(rowsum_pkg::COLS - 1))));

endmodule

//--- source/rowsum_pkg.sv
package rowsum_pkg;

  // frame geometry.
  localparam int ROWS     = 4;
  localparam int COLS     = 11;
  localparam int LANES    = 4;
  localparam int WIN      = 8;

  localparam int SAMPLE_W = 8;
  localparam int SUM_W    = 11;
  localparam int ADDR_W   = 6;

  // warm-up count the controller must pass before the first row.
  localparam int WARMUP   = 2;
  // cycles from the finish state to the last result leaving the collector.
  localparam int DRAIN    = 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [3:0]        col_t;
  typedef logic [1:0]        row_t;

  // lane 0 sits in the low bits.
  typedef struct packed {
    logic [LANES-1:0][SAMPLE_W-1:0] lane;
  } sample_vec_t;

  typedef struct packed {
    logic [LANES-1:0][SUM_W-1:0] lane;
  } sum_vec_t;

  typedef struct packed {
    row_t     row;
    col_t     col;
    sum_vec_t sums;
  } result_t;

  typedef struct packed {
    logic start_en;
    logic ld_en;
    logic count_en;
    logic sum_en;
    logic cum_en;
    logic done_o;
    logic progress_done;
    logic reset_en;
  } ctrl_t;

  typedef enum logic [2:0] {
    st_idle       = 3'b000,
    st_start      = 3'b001,
    st_start_row  = 3'b010,
    st_sum_en     = 3'b011,
    st_cum_en     = 3'b100,
    st_finish_all = 3'b101
  } ctrl_state_t;

endpackage
